// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = cpu_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# pass only if the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/bios.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/step_seq.sv
hdl/cpu_top.sv
testbench/cpu_tb.sv

// ==== hdl/bios.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module bios import cpu_pkg::*; (
	input  logic [`PC_W-1:0] pc,
	output logic [`XLEN-1:0] instr
);

	function automatic logic [`XLEN-1:0] enc_i(opcode_e opc, logic [`REG_AW-1:0] rs,
		logic [`REG_AW-1:0] rt, logic [`IMM_W-1:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic logic [`XLEN-1:0] enc_r(logic [`REG_AW-1:0] rs,
		logic [`REG_AW-1:0] rt, logic [`REG_AW-1:0] rd, funct_e fn);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [`XLEN-1:0] enc_j(opcode_e opc, logic [`PC_W-1:0] addr);
		return {opc, addr};
	endfunction

	always_comb begin
		instr = enc_j(op_halt, '0);                         // anything past the program
		if (pc < `PC_W'(`BIOS_SIZE)) begin
			case (pc)
				0:  instr = enc_j(op_j, 26'd46);                 // to main
				1:  instr = enc_i(op_addi, 5'd30, 5'd30, 16'd8); // sort entry, new frame
				2:  instr = enc_i(op_sw, 5'd30, 5'd6, -16'sd5);  // save base
				3:  instr = enc_i(op_sw, 5'd30, 5'd7, -16'sd4);  // save length
				4:  instr = enc_i(op_li, 5'd0, 5'd20, 16'd0);
				5:  instr = enc_i(op_sw, 5'd30, 5'd20, -16'sd3); // i = 0
				6:  instr = enc_i(op_lw, 5'd30, 5'd10, -16'sd4); // outer loop
				7:  instr = enc_i(op_subi, 5'd10, 5'd21, 16'd1);
				8:  instr = enc_i(op_lw, 5'd30, 5'd11, -16'sd3);
				9:  instr = enc_r(5'd11, 5'd21, 5'd22, fn_lt);   // i < n-1
				10: instr = enc_i(op_jf, 5'd22, 5'd0, 16'd45);   // done, return
				11: instr = enc_i(op_sw, 5'd30, 5'd11, -16'sd1); // min = i
				12: instr = enc_i(op_addi, 5'd11, 5'd23, 16'd1);
				13: instr = enc_i(op_sw, 5'd30, 5'd23, -16'sd2); // j = i+1
				14: instr = enc_i(op_lw, 5'd30, 5'd12, -16'sd2); // inner loop
				15: instr = enc_r(5'd12, 5'd10, 5'd24, fn_lt);   // j < n
				16: instr = enc_i(op_jf, 5'd24, 5'd0, 16'd29);
				17: instr = enc_i(op_lw, 5'd30, 5'd13, -16'sd5);
				18: instr = enc_r(5'd13, 5'd12, 5'd25, fn_add);
				19: instr = enc_i(op_lw, 5'd25, 5'd25, 16'd0);   // a[j]
				20: instr = enc_i(op_lw, 5'd30, 5'd14, -16'sd1);
				21: instr = enc_r(5'd13, 5'd14, 5'd26, fn_add);
				22: instr = enc_i(op_lw, 5'd26, 5'd26, 16'd0);   // a[min]
				23: instr = enc_r(5'd25, 5'd26, 5'd27, fn_lt);
				24: instr = enc_i(op_jf, 5'd27, 5'd0, 16'd26);
				25: instr = enc_i(op_sw, 5'd30, 5'd12, -16'sd1); // min = j
				26: instr = enc_i(op_addi, 5'd12, 5'd28, 16'd1);
				27: instr = enc_i(op_sw, 5'd30, 5'd28, -16'sd2);
				28: instr = enc_j(op_j, 26'd14);
				29: instr = enc_i(op_lw, 5'd30, 5'd15, -16'sd1);
				30: instr = enc_r(5'd11, 5'd15, 5'd29, fn_ne);
				31: instr = enc_i(op_jf, 5'd29, 5'd0, 16'd42);   // no swap needed
				32: instr = enc_r(5'd13, 5'd11, 5'd20, fn_add);  // swap a[i], a[min]
				33: instr = enc_i(op_lw, 5'd20, 5'd20, 16'd0);
				34: instr = enc_i(op_sw, 5'd30, 5'd20, 16'd0);   // temp on the frame
				35: instr = enc_r(5'd13, 5'd15, 5'd21, fn_add);
				36: instr = enc_i(op_lw, 5'd21, 5'd21, 16'd0);
				37: instr = enc_r(5'd13, 5'd11, 5'd22, fn_add);
				38: instr = enc_i(op_sw, 5'd22, 5'd21, 16'd0);
				39: instr = enc_r(5'd13, 5'd15, 5'd23, fn_add);
				40: instr = enc_i(op_lw, 5'd30, 5'd16, 16'd0);
				41: instr = enc_i(op_sw, 5'd23, 5'd16, 16'd0);
				42: instr = enc_i(op_addi, 5'd11, 5'd24, 16'd1);
				43: instr = enc_i(op_sw, 5'd30, 5'd24, -16'sd3); // i++
				44: instr = enc_j(op_j, 26'd6);
				45: instr = enc_r(5'd31, 5'd0, 5'd0, fn_jr);     // return
				46: instr = enc_i(op_addi, 5'd30, 5'd30, 16'd5); // main
				47: instr = enc_i(op_la, 5'd30, 5'd10, -16'sd4); // array base
				48: instr = enc_i(op_li, 5'd0, 5'd20, 16'd9);
				49: instr = enc_i(op_sw, 5'd10, 5'd20, 16'd0);
				50: instr = enc_i(op_li, 5'd0, 5'd21, 16'd6);
				51: instr = enc_i(op_sw, 5'd10, 5'd21, 16'd1);
				52: instr = enc_i(op_li, 5'd0, 5'd22, 16'd8);
				53: instr = enc_i(op_sw, 5'd10, 5'd22, 16'd2);
				54: instr = enc_i(op_li, 5'd0, 5'd23, 16'd7);
				55: instr = enc_i(op_sw, 5'd10, 5'd23, 16'd3);
				56: instr = enc_i(op_la, 5'd30, 5'd6, -16'sd4);  // arg base
				57: instr = enc_i(op_li, 5'd0, 5'd7, 16'd4);     // arg length
				58: instr = enc_j(op_jal, 26'd1);
				59: instr = enc_i(op_mov, 5'd1, 5'd11, 16'd0);
				60: instr = enc_i(op_subi, 5'd30, 5'd30, 16'd8);
				61: instr = enc_i(op_in, 5'd0, 5'd24, 16'd0);    // read index
				62: instr = enc_i(op_sw, 5'd30, 5'd24, 16'd0);
				63: instr = enc_i(op_la, 5'd30, 5'd12, -16'sd4);
				64: instr = enc_i(op_lw, 5'd30, 5'd13, 16'd0);
				65: instr = enc_r(5'd12, 5'd13, 5'd25, fn_add);
				66: instr = enc_i(op_lw, 5'd25, 5'd25, 16'd0);   // a[index]
				67: instr = enc_i(op_mov, 5'd25, 5'd6, 16'd0);
				68: instr = enc_i(op_li, 5'd0, 5'd7, 16'd2);
				69: instr = enc_i(op_out, 5'd0, 5'd6, 16'd2);    // to port 2
				70: instr = enc_j(op_halt, 26'd0);
				default: ;
			endcase
		end
	end

endmodule

// ==== hdl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define XLEN        32              // data word
`define PC_W        26              // program counter, also the j/jal field
`define IMM_W       16              // I-type immediate field

// register file
`define REG_N       32              // r0 reads as zero
`define REG_AW      5
`define LINK_REG    5'd31           // jal return address

// data memory, addresses wrap at the depth
`define DMEM_AW     8
`define DMEM_DEPTH  (1 << `DMEM_AW)

// boot program and ports
`define BIOS_SIZE   71              // words in the ROM
`define OUT_PORT_W  16

`endif

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

	// major opcode in instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'd0,
		op_addi  = 6'd1,
		op_subi  = 6'd2,
		op_mov   = 6'd14,
		op_lw    = 6'd15,
		op_li    = 6'd16,
		op_la    = 6'd17,
		op_sw    = 6'd18,
		op_in    = 6'd19,
		op_out   = 6'd20,
		op_jf    = 6'd21,   // jump if rs is zero
		op_j     = 6'd22,
		op_jal   = 6'd23,
		op_halt  = 6'd24
	} opcode_e;

	// R-type function in instr[5:0]
	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_ne  = 6'd13,
		fn_lt  = 6'd14,
		fn_jr  = 6'd18
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_pass_b,
		alu_lt,             // signed, result is 0 or 1
		alu_ne
	} alu_op_e;

	typedef enum logic [2:0] {
		step_fetch,
		step_decode,
		step_exec,
		step_mem,
		step_halted
	} step_e;

endpackage

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top import cpu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`XLEN-1:0]       in_data,
	output logic                   in_rd,
	output logic                   out_wr,
	output logic [`XLEN-1:0]       out_data,
	output logic [`OUT_PORT_W-1:0] out_port,
	output logic                   halted
);

	logic               fetch_en;
	logic               decode_en;
	logic               exec_en;
	logic               mem_en;
	logic               halt_seen;
	logic [`XLEN-1:0]   instr_q;
	logic [`PC_W-1:0]   pc_plus1;
	logic               take_jump;
	logic [`PC_W-1:0]   jump_target;
	opcode_e            op;
	alu_op_e            alu_op;
	logic [`XLEN-1:0]   rs_val;
	logic [`XLEN-1:0]   rt_val;
	logic [`XLEN-1:0]   imm_sext;
	logic [`PC_W-1:0]   jaddr;
	logic [`REG_AW-1:0] dest;
	logic               writes_reg;
	logic [`XLEN-1:0]   result;
	logic [`XLEN-1:0]   store_val;
	logic               wb_en;
	logic [`REG_AW-1:0] wb_addr;
	logic [`XLEN-1:0]   wb_data;

	step_seq i_step_seq (
		.clk       (clk),
		.rst       (rst),
		.halt_seen (halt_seen),
		.fetch_en  (fetch_en),
		.decode_en (decode_en),
		.exec_en   (exec_en),
		.mem_en    (mem_en),
		.halted    (halted)
	);

	fetch_stage i_fetch_stage (
		.clk         (clk),
		.rst         (rst),
		.fetch_en    (fetch_en),
		.take_jump   (take_jump),
		.jump_target (jump_target),
		.instr_q     (instr_q),
		.pc_plus1    (pc_plus1)
	);

	decode_stage i_decode_stage (
		.clk        (clk),
		.rst        (rst),
		.decode_en  (decode_en),
		.instr_q    (instr_q),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.op         (op),
		.alu_op     (alu_op),
		.rs_val     (rs_val),
		.rt_val     (rt_val),
		.imm_sext   (imm_sext),
		.jaddr      (jaddr),
		.dest       (dest),
		.writes_reg (writes_reg)
	);

	execute_stage i_execute_stage (
		.clk         (clk),
		.rst         (rst),
		.exec_en     (exec_en),
		.op          (op),
		.alu_op      (alu_op),
		.rs_val      (rs_val),
		.rt_val      (rt_val),
		.imm_sext    (imm_sext),
		.jaddr       (jaddr),
		.pc_plus1    (pc_plus1),
		.result      (result),
		.store_val   (store_val),
		.take_jump   (take_jump),
		.jump_target (jump_target)
	);

	mem_stage i_mem_stage (
		.clk        (clk),
		.rst        (rst),
		.mem_en     (mem_en),
		.op         (op),
		.result     (result),
		.store_val  (store_val),
		.dest       (dest),
		.writes_reg (writes_reg),
		.in_data    (in_data),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.in_rd      (in_rd),
		.out_wr     (out_wr),
		.out_data   (out_data),
		.out_port   (out_port),
		.halt_seen  (halt_seen)
	);

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               decode_en,
	input  logic [`XLEN-1:0]   instr_q,
	input  logic               wb_en,
	input  logic [`REG_AW-1:0] wb_addr,
	input  logic [`XLEN-1:0]   wb_data,
	output opcode_e            op,
	output alu_op_e            alu_op,
	output logic [`XLEN-1:0]   rs_val,
	output logic [`XLEN-1:0]   rt_val,
	output logic [`XLEN-1:0]   imm_sext,
	output logic [`PC_W-1:0]   jaddr,
	output logic [`REG_AW-1:0] dest,
	output logic               writes_reg
);

	logic [`XLEN-1:0]   regs [`REG_N];
	logic [5:0]         opc;
	logic [5:0]         fn;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	logic [`REG_AW-1:0] rd;
	logic [`IMM_W-1:0]  imm;
	logic [`XLEN-1:0]   rs_rd;
	logic [`XLEN-1:0]   rt_rd;
	opcode_e            op_d;
	alu_op_e            alu_d;
	logic               wr_d;
	logic [`REG_AW-1:0] dest_d;
	logic [`PC_W-1:0]   jaddr_d;

	assign opc = instr_q[31:26];
	assign rs  = instr_q[25:21];
	assign rt  = instr_q[20:16];
	assign rd  = instr_q[15:11];        // R-type only
	assign fn  = instr_q[5:0];
	assign imm = instr_q[`IMM_W-1:0];

	assign rs_rd = (rs == '0) ? '0 : regs[rs];
	assign rt_rd = (rt == '0) ? '0 : regs[rt];

	// register file, written back in the memory step
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_addr != '0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	always_comb begin
		op_d    = opcode_e'(opc);
		alu_d   = alu_add;
		wr_d    = 1'b0;
		dest_d  = rt;                       // I-type destination
		jaddr_d = instr_q[`PC_W-1:0];
		case (opc)
			op_rtype: begin
				dest_d = rd;
				wr_d   = 1'b1;
				case (fn)
					fn_add: alu_d = alu_add;
					fn_lt:  alu_d = alu_lt;
					fn_ne:  alu_d = alu_ne;
					fn_jr: begin                // becomes j with the target from rs
						op_d    = op_j;
						wr_d    = 1'b0;
						jaddr_d = rs_rd[`PC_W-1:0];
					end
					default: wr_d = 1'b0;
				endcase
			end
			op_addi, op_mov, op_lw, op_la: wr_d = 1'b1;
			op_subi: begin
				alu_d = alu_sub;
				wr_d  = 1'b1;
			end
			op_li, op_in: begin
				alu_d = alu_pass_b;
				wr_d  = 1'b1;
			end
			op_out, op_jf: alu_d = alu_pass_b;  // immediate carried in the result
			op_jal: begin
				dest_d = `LINK_REG;
				wr_d   = 1'b1;
			end
			op_sw, op_j, op_halt: ;
			default: op_d = op_halt;            // unknown opcode stops the core
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			op         <= op_rtype;
			alu_op     <= alu_add;
			writes_reg <= 1'b0;
		end else if (decode_en) begin
			op         <= op_d;
			alu_op     <= alu_d;
			writes_reg <= wr_d;
		end
	end

	always_ff @(posedge clk) begin
		if (decode_en) begin
			rs_val   <= rs_rd;
			rt_val   <= rt_rd;
			imm_sext <= {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
			jaddr    <= jaddr_d;
			dest     <= dest_d;
		end
	end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage import cpu_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             exec_en,
	input  opcode_e          op,
	input  alu_op_e          alu_op,
	input  logic [`XLEN-1:0] rs_val,
	input  logic [`XLEN-1:0] rt_val,
	input  logic [`XLEN-1:0] imm_sext,
	input  logic [`PC_W-1:0] jaddr,
	input  logic [`PC_W-1:0] pc_plus1,
	output logic [`XLEN-1:0] result,
	output logic [`XLEN-1:0] store_val,
	output logic             take_jump,
	output logic [`PC_W-1:0] jump_target
);

	logic [`XLEN-1:0] opnd_b;
	logic [`XLEN-1:0] alu_y;
	logic [`XLEN-1:0] res_d;
	logic             jump_d;
	logic [`PC_W-1:0] target_d;

	always_comb begin
		case (op)
			op_rtype: opnd_b = rt_val;
			op_mov:   opnd_b = '0;          // plain copy of rs
			default:  opnd_b = imm_sext;
		endcase
	end

	always_comb begin
		case (alu_op)
			alu_add:    alu_y = rs_val + opnd_b;    // also lw/sw/la address
			alu_sub:    alu_y = rs_val - opnd_b;
			alu_pass_b: alu_y = opnd_b;
			alu_lt:     alu_y = {{(`XLEN-1){1'b0}}, $signed(rs_val) < $signed(opnd_b)};
			alu_ne:     alu_y = {{(`XLEN-1){1'b0}}, rs_val != opnd_b};
			default:    alu_y = '0;
		endcase
	end

	assign res_d = (op == op_jal) ? {{(`XLEN-`PC_W){1'b0}}, pc_plus1} : alu_y;

	always_comb begin
		jump_d   = 1'b0;
		target_d = jaddr;
		case (op)
			op_jf: begin
				jump_d   = (rs_val == '0);
				target_d = imm_sext[`PC_W-1:0];   // absolute word address
			end
			op_j, op_jal: jump_d = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			take_jump <= 1'b0;
		end else if (exec_en) begin
			take_jump <= jump_d;
		end
	end

	always_ff @(posedge clk) begin
		if (exec_en) begin
			result      <= res_d;
			store_val   <= rt_val;
			jump_target <= target_d;
		end
	end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_stage (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetch_en,
	input  logic             take_jump,
	input  logic [`PC_W-1:0] jump_target,
	output logic [`XLEN-1:0] instr_q,
	output logic [`PC_W-1:0] pc_plus1
);

	logic [`PC_W-1:0] pc;           // sequential address for the next fetch
	logic [`PC_W-1:0] fetch_addr;
	logic [`XLEN-1:0] rom_word;

	// a jump resolved in the last execute step redirects this fetch
	assign fetch_addr = take_jump ? jump_target : pc;

	bios i_bios (
		.pc    (fetch_addr),
		.instr (rom_word)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (fetch_en) begin
			pc <= fetch_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_en) begin
			instr_q <= rom_word;
		end
	end

	assign pc_plus1 = pc;           // link value for jal

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mem_stage import cpu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mem_en,
	input  opcode_e                op,
	input  logic [`XLEN-1:0]       result,
	input  logic [`XLEN-1:0]       store_val,
	input  logic [`REG_AW-1:0]     dest,
	input  logic                   writes_reg,
	input  logic [`XLEN-1:0]       in_data,
	output logic                   wb_en,
	output logic [`REG_AW-1:0]     wb_addr,
	output logic [`XLEN-1:0]       wb_data,
	output logic                   in_rd,
	output logic                   out_wr,
	output logic [`XLEN-1:0]       out_data,
	output logic [`OUT_PORT_W-1:0] out_port,
	output logic                   halt_seen
);

	logic [`XLEN-1:0]    dmem [`DMEM_DEPTH];
	logic [`DMEM_AW-1:0] addr;
	logic [`XLEN-1:0]    load_data;

	assign addr      = result[`DMEM_AW-1:0];    // wraps
	assign load_data = dmem[addr];              // async read

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (mem_en && op == op_sw) begin
			dmem[addr] <= store_val;
		end
	end

	always_comb begin
		case (op)
			op_lw:   wb_data = load_data;
			op_in:   wb_data = in_data;         // sampled with the in_rd strobe
			default: wb_data = result;
		endcase
	end

	assign wb_en   = mem_en && writes_reg;
	assign wb_addr = dest;

	// port strobes last exactly the memory step
	assign in_rd     = mem_en && (op == op_in);
	assign out_wr    = mem_en && (op == op_out);
	assign out_data  = store_val;
	assign out_port  = result[`OUT_PORT_W-1:0];
	assign halt_seen = mem_en && (op == op_halt);

endmodule

// ==== hdl/step_seq.sv ====
`timescale 1ns/1ps

module step_seq import cpu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic halt_seen,
	output logic fetch_en,
	output logic decode_en,
	output logic exec_en,
	output logic mem_en,
	output logic halted
);

	step_e state;
	step_e state_d;

	always_comb begin
		case (state)
			step_fetch:  state_d = step_decode;
			step_decode: state_d = step_exec;
			step_exec:   state_d = step_mem;
			step_mem:    state_d = halt_seen ? step_halted : step_fetch;
			default:     state_d = step_halted;  // parked until reset
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= step_fetch;        // first fetch right after reset drops
		end else begin
			state <= state_d;
		end
	end

	assign fetch_en  = (state == step_fetch);
	assign decode_en = (state == step_decode);
	assign exec_en   = (state == step_exec);
	assign mem_en    = (state == step_mem);
	assign halted    = (state == step_halted);

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

	localparam int HALT_TIMEOUT = 5000;         // cycles allowed for one program run
	localparam int QUIET_CYCLES = 50;

	logic                   clk;
	logic                   rst;
	logic [`XLEN-1:0]       in_data;
	logic                   in_rd;
	logic                   out_wr;
	logic [`XLEN-1:0]       out_data;
	logic [`OUT_PORT_W-1:0] out_port;
	logic                   halted;

	int                     errors;
	int                     timeouts;
	int                     in_rd_cnt;
	int                     out_wr_cnt;
	logic                   in_before_out;
	logic [`XLEN-1:0]       out_seen;
	logic [`OUT_PORT_W-1:0] port_seen;
	int unsigned            rand_idx;

	cpu_top i_cpu_top (
		.clk      (clk),
		.rst      (rst),
		.in_data  (in_data),
		.in_rd    (in_rd),
		.out_wr   (out_wr),
		.out_data (out_data),
		.out_port (out_port),
		.halted   (halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// strobe monitor, counters are cleared while rst is high
	always @(posedge clk) begin
		if (!rst) begin
			if (in_rd) begin
				in_rd_cnt++;
			end
			if (out_wr) begin
				out_wr_cnt++;
				out_seen      = out_data;
				port_seen     = out_port;
				in_before_out = (in_rd_cnt > 0);
			end
		end
	end

	halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
		else begin
			errors++;
			$display("halted dropped while reset was low");
		end

	quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
		halted |-> !in_rd && !out_wr)
		else begin
			errors++;
			$display("port strobe seen while the core was halted");
		end

	// reference result, sorted copy of the array the boot program builds
	function automatic int sorted_element(int idx);
		int arr [4];
		int tmp;
		arr = '{9, 6, 8, 7};
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3 - i; j++) begin
				if (arr[j] > arr[j+1]) begin
					tmp      = arr[j];
					arr[j]   = arr[j+1];
					arr[j+1] = tmp;
				end
			end
		end
		return arr[idx];
	endfunction

	task automatic check_value(string name, string what, logic [31:0] expected,
		logic [31:0] actual);
		assert (expected == actual)
			else begin
				errors++;
				$display("** Error [%s] %s expected %0d actual %0d", name, what, expected,
					actual);
			end
	endtask

	task automatic check_quiet(string what);
		assert (!in_rd && !out_wr && !halted)
			else begin
				errors++;
				$display("port strobe or halted high %s", what);
			end
	endtask

	// called on a falling edge, returns on a falling edge
	task automatic reset_dut();
		rst           = 1'b1;
		in_rd_cnt     = 0;
		out_wr_cnt    = 0;
		in_before_out = 1'b0;
		out_seen      = '0;
		port_seen     = '0;
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			check_quiet("during reset");
		end
		rst = 1'b0;
		repeat (3) begin                        // fetch, decode, execute of the first word
			@(negedge clk);
			check_quiet("before the first instruction finished");
		end
	endtask

	task automatic run_program(string name, int idx);
		int          cycles;
		logic [31:0] expected;
		cycles   = 0;
		expected = sorted_element(idx);
		in_data  = idx;                         // held for the whole run
		reset_dut();
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			timeouts++;
			$display("timeout in %s: halted did not rise within %0d cycles", name,
				HALT_TIMEOUT);
		end else begin
			check_value(name, "out_wr count", 1, out_wr_cnt);
			check_value(name, "in_rd count", 1, in_rd_cnt);
			check_value(name, "out_data", expected, out_seen);
			check_value(name, "out_port", 2, port_seen);
			assert (in_before_out)
				else begin
					errors++;
					$display("in %s the in_rd strobe did not come before out_wr", name);
				end
			repeat (QUIET_CYCLES) @(negedge clk);   // halt must hold, ports stay quiet
			assert (halted)
				else begin
					errors++;
					$display("in %s halted did not stay high", name);
				end
			check_value(name, "out_wr count after halt", 1, out_wr_cnt);
			check_value(name, "in_rd count after halt", 1, in_rd_cnt);
		end
	endtask

	initial begin
		rst           = 1'b1;
		in_data       = '0;
		errors        = 0;
		timeouts      = 0;
		in_rd_cnt     = 0;
		out_wr_cnt    = 0;
		in_before_out = 1'b0;
		out_seen      = '0;
		port_seen     = '0;
		void'($urandom(32'h9f4f_6e25));
		@(negedge clk);
		for (int i = 0; i < 4; i++) begin
			run_program($sformatf("sorted_idx%0d", i), i);
		end
		rand_idx = $urandom % 4;
		run_program("random_idx", rand_idx);
		$display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
